// File: flist.f
+incdir+verification
verilog/vpu_isa_pkg.sv
verilog/vpu_ucode_pkg.sv
verilog/inst_decoder.sv
verilog/ucode_rom.sv
verilog/useq.sv
verilog/agu.sv
verilog/lane_alu.sv
verilog/vpu_control.sv
verification/vpu_checker.sv
verification/tb_vpu.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f flist.f --top-module tb_vpu -o Vtb_vpu
	out=$$(./obj_dir/Vtb_vpu); echo "$$out"; echo "$$out" | grep -qx 'All checks passed'

clean:
	rm -rf obj_dir

// File: verification/mem_pattern.svh
// source word as a function of the whole address
function automatic logic [63:0] mem_pattern(logic [7:0] addr);
    logic [15:0] x;
    x = {addr, ~addr} ^ 16'h3c5a;
    return {x * 16'd3 + 16'h1234, x ^ 16'hbeef, {addr[3:0], addr[7:4], addr}, ~x};
endfunction

// File: verification/tb_vpu.sv
`timescale 1ns/1ps

module tb_vpu;
    import vpu_isa_pkg::*;

    localparam int N_INST  = 30;
    localparam int MAX_LEN = 63;

    logic                  clk;
    logic                  rstn;
    inst_t                 inst;
    logic                  inst_valid;
    logic                  inst_credit;
    logic                  finish;
    logic                  wr_en;
    logic [ADDR_WIDTH-1:0] rd_addr_a;
    logic [ADDR_WIDTH-1:0] rd_addr_b;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [DATA_WIDTH-1:0] rd_data_a;
    logic [DATA_WIDTH-1:0] rd_data_b;
    logic [DATA_WIDTH-1:0] wr_data;
    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];
    int                    n_sent;
    int                    n_returned;
    int                    total_len;
    int                    end_errors;
    int                    errors;
    int                    n_writes;
    int                    n_done;
    int                    n_credits;

    `include "mem_pattern.svh"

    vpu_control UUT (
        .clk(clk), .rstn(rstn), .inst(inst), .inst_valid(inst_valid),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .inst_credit(inst_credit),
        .finish(finish), .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    vpu_checker u_chk (
        .clk(clk), .rstn(rstn), .inst(inst), .inst_valid(inst_valid),
        .inst_credit(inst_credit), .finish(finish), .rd_addr_a(rd_addr_a),
        .rd_addr_b(rd_addr_b), .wr_en(wr_en),
        .wr_addr(wr_addr), .wr_data(wr_data), .errors(errors),
        .n_writes(n_writes), .n_done(n_done), .n_credits(n_credits)
    );

    always #50 clk = ~clk;

    // memory with one cycle read latency
    always @(posedge clk) begin
        rd_data_a <= mem[rd_addr_a];
        rd_data_b <= mem[rd_addr_b];
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            n_returned <= 0;
        end else if (inst_credit) begin
            n_returned <= n_returned + 1;
        end
    end

    // sources in the lower half, destinations in the upper half
    function automatic inst_t random_inst(int k);
        inst_t                v;
        int                   sel;
        logic [LEN_WIDTH-1:0] len;
        logic [ADDR_WIDTH-1:0] d;
        v   = '0;
        sel = (k < 3) ? k : int'($urandom_range(2));
        len = LEN_WIDTH'($urandom_range(MAX_LEN, 1));
        if (k == 3) begin
            len = 1;
        end else if (k == 4) begin
            len = LEN_WIDTH'(MAX_LEN);
        end
        d = ADDR_WIDTH'($urandom_range(256 - int'(len), 128));
        if (sel == 2) begin
            v.fill.opcode = OP_FILL;
            v.fill.length = len;
            v.fill.d_base = d;
            v.fill.value  = LANE_WIDTH'($urandom);
        end else begin
            v.vec.opcode = (sel == 0) ? OP_VADD : OP_VMUL;
            v.vec.length = len;
            v.vec.d_base = d;
            v.vec.a_base = ADDR_WIDTH'($urandom_range(128 - int'(len)));
            v.vec.b_base = ADDR_WIDTH'($urandom_range(128 - int'(len)));
            v.vec.negate = 1'($urandom_range(1));
        end
        return v;
    endfunction

    initial begin
        clk        = 1'b0;
        rstn       = 1'b0;
        inst       = '0;
        inst_valid = 1'b0;
        rd_data_a  <= '0;
        rd_data_b  <= '0;
        n_sent     = 0;
        total_len  = 0;
        end_errors = 0;
        void'($urandom(32'h72c9));
        for (int a = 0; a < 2**ADDR_WIDTH; a++) begin
            mem[a] <= mem_pattern(ADDR_WIDTH'(a));
        end
        repeat (16) @(negedge clk);
        rstn = 1'b1;
        repeat (2) @(negedge clk);
        for (int k = 0; k < N_INST; k++) begin
            // one credit at start, one back per pulse
            while (1 + n_returned - n_sent == 0) begin
                @(negedge clk);
            end
            inst       = random_inst(k);
            inst_valid = 1'b1;
            n_sent++;
            total_len += int'(inst.vec.length);
            @(negedge clk);
            inst_valid = 1'b0;
        end
        wait (n_done == N_INST);
        repeat (4) @(negedge clk);
        if (n_credits != N_INST) begin
            end_errors++;
            $display("%0d credits returned for %0d instructions", n_credits, N_INST);
        end
        if (n_writes != total_len) begin
            end_errors++;
            $display("%0d writes seen, %0d expected", n_writes, total_len);
        end
        $display("instructions %0d, writes %0d, finishes %0d, credits %0d, errors %0d",
                 N_INST, n_writes, n_done, n_credits, errors + end_errors);
        if (errors + end_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // budget per instruction covers the longest vector plus overhead
    initial begin
        repeat (16 + N_INST * (MAX_LEN + 20)) @(posedge clk);
        $display("watchdog expired with %0d of %0d instructions finished", n_done, N_INST);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: verification/vpu_checker.sv
`timescale 1ns/1ps

module vpu_checker (
    input  logic                               clk,
    input  logic                               rstn,
    input  vpu_isa_pkg::inst_t                 inst,
    input  logic                               inst_valid,
    input  logic                               inst_credit,
    input  logic                               finish,
    input  logic [vpu_isa_pkg::ADDR_WIDTH-1:0] rd_addr_a,
    input  logic [vpu_isa_pkg::ADDR_WIDTH-1:0] rd_addr_b,
    input  logic                               wr_en,
    input  logic [vpu_isa_pkg::ADDR_WIDTH-1:0] wr_addr,
    input  logic [vpu_isa_pkg::DATA_WIDTH-1:0] wr_data,
    output int                                 errors,
    output int                                 n_writes,
    output int                                 n_done,
    output int                                 n_credits
);
    import vpu_isa_pkg::*;

    inst_t                 pending[$];
    int                    word_idx;
    int                    n_accepted;
    logic                  seen_inst;
    logic [ADDR_WIDTH-1:0] exp_addr;
    logic [DATA_WIDTH-1:0] exp_data;
    logic [ADDR_WIDTH-1:0] rd_a_d1;
    logic [ADDR_WIDTH-1:0] rd_a_d2;
    logic [ADDR_WIDTH-1:0] rd_b_d1;
    logic [ADDR_WIDTH-1:0] rd_b_d2;

    `include "mem_pattern.svh"

    // expected word idx of an instruction
    function automatic logic [DATA_WIDTH-1:0] expected_word(inst_t ins, int idx);
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        logic [DATA_WIDTH-1:0] w;
        logic [LANE_WIDTH-1:0] r;
        a = mem_pattern(ins.vec.a_base + ADDR_WIDTH'(idx));
        b = mem_pattern(ins.vec.b_base + ADDR_WIDTH'(idx));
        w = '0;
        for (int i = 0; i < N_LANES; i++) begin
            if (ins.vec.opcode == OP_FILL) begin
                r = ins.fill.value;
            end else if (ins.vec.opcode == OP_VMUL) begin
                r = a[i*LANE_WIDTH +: LANE_WIDTH] * b[i*LANE_WIDTH +: LANE_WIDTH];
            end else begin
                r = a[i*LANE_WIDTH +: LANE_WIDTH] + b[i*LANE_WIDTH +: LANE_WIDTH];
            end
            if (ins.vec.opcode != OP_FILL && ins.vec.negate) begin
                r = -r;
            end
            w[i*LANE_WIDTH +: LANE_WIDTH] = r;
        end
        return w;
    endfunction

    always @(posedge clk) begin
        if (!rstn) begin
            errors     = 0;
            n_writes   = 0;
            n_done     = 0;
            n_credits  = 0;
            n_accepted = 0;
            word_idx   = 0;
            seen_inst  = 1'b0;
        end else begin
            if (!seen_inst && (wr_en || inst_credit || finish)) begin
                errors++;
                $display("output active before the first instruction");
            end
            if (wr_en) begin
                n_writes++;
                if (pending.size() == 0) begin
                    errors++;
                    $display("write to %h with no instruction in progress", wr_addr);
                end else if (word_idx >= int'(pending[0].vec.length)) begin
                    errors++;
                    $display("more writes than the instruction length");
                end else begin
                    exp_addr = pending[0].vec.d_base + ADDR_WIDTH'(word_idx);
                    exp_data = expected_word(pending[0], word_idx);
                    if (wr_addr !== exp_addr) begin
                        errors++;
                        $display("[FAIL] wr_addr expected %h got %h", exp_addr, wr_addr);
                    end
                    if (wr_data !== exp_data) begin
                        errors++;
                        $display("[FAIL] wr_data expected %h got %h", exp_data, wr_data);
                    end
                    if (pending[0].vec.opcode != OP_FILL) begin
                        exp_addr = pending[0].vec.a_base + ADDR_WIDTH'(word_idx);
                        if (rd_a_d2 !== exp_addr) begin
                            errors++;
                            $display("[FAIL] rd_addr_a expected %h got %h", exp_addr, rd_a_d2);
                        end
                        exp_addr = pending[0].vec.b_base + ADDR_WIDTH'(word_idx);
                        if (rd_b_d2 !== exp_addr) begin
                            errors++;
                            $display("[FAIL] rd_addr_b expected %h got %h", exp_addr, rd_b_d2);
                        end
                    end
                end
                word_idx++;
            end
            if (finish) begin
                n_done++;
                if (pending.size() == 0) begin
                    errors++;
                    $display("finish with no instruction in progress");
                end else begin
                    if (word_idx != int'(pending[0].vec.length)) begin
                        errors++;
                        $display("finish after %0d writes, expected %0d", word_idx,
                                 pending[0].vec.length);
                    end
                    void'(pending.pop_front());
                end
                word_idx = 0;
            end
            if (inst_credit) begin
                n_credits++;
                if (n_credits > n_accepted) begin
                    errors++;
                    $display("credit returned without an accepted instruction");
                end
            end
            if (inst_valid) begin
                pending.push_back(inst);
                n_accepted++;
                seen_inst = 1'b1;
            end
        end
        // read addresses lead their write by two cycles
        rd_a_d2 = rd_a_d1;
        rd_a_d1 = rd_addr_a;
        rd_b_d2 = rd_b_d1;
        rd_b_d1 = rd_addr_b;
    end

endmodule

// File: verilog/vpu_control.sv
`timescale 1ns/1ps

module vpu_control (
    input  logic                               clk,
    input  logic                               rstn,
    input  vpu_isa_pkg::inst_t                 inst,
    input  logic                               inst_valid,
    input  logic [vpu_isa_pkg::DATA_WIDTH-1:0] rd_data_a,
    input  logic [vpu_isa_pkg::DATA_WIDTH-1:0] rd_data_b,
    output logic                               inst_credit,
    output logic                               finish,
    output logic [vpu_isa_pkg::ADDR_WIDTH-1:0] rd_addr_a,
    output logic [vpu_isa_pkg::ADDR_WIDTH-1:0] rd_addr_b,
    output logic                               wr_en,
    output logic [vpu_isa_pkg::ADDR_WIDTH-1:0] wr_addr,
    output logic [vpu_isa_pkg::DATA_WIDTH-1:0] wr_data
);
    import vpu_isa_pkg::*;
    import vpu_ucode_pkg::*;

    logic                   start;
    logic                   prog_done;
    logic                   busy;
    logic                   negate;
    logic                   issue;
    logic                   clr;
    logic                   wr_step;
    logic [OP_WIDTH-1:0]    op;
    logic [LEN_WIDTH-1:0]   length;
    logic [LANE_WIDTH-1:0]  fill_const;
    logic [ADDR_WIDTH-1:0]  a_base;
    logic [ADDR_WIDTH-1:0]  b_base;
    logic [ADDR_WIDTH-1:0]  d_base;
    logic [UPC_WIDTH-1:0]   upc_entry;
    logic [UPC_WIDTH-1:0]   upc;
    logic [UINST_WIDTH-1:0] uinst;

    inst_decoder u_dec (
        .clk(clk), .rstn(rstn), .inst(inst), .inst_valid(inst_valid),
        .prog_done(prog_done), .busy(busy), .inst_credit(inst_credit),
        .finish(finish), .start(start), .op(op), .length(length),
        .negate(negate), .fill_const(fill_const), .a_base(a_base),
        .b_base(b_base), .d_base(d_base), .upc_entry(upc_entry)
    );

    ucode_rom u_rom (.clk(clk), .upc(upc), .uinst(uinst));

    useq u_seq (
        .clk(clk), .rstn(rstn), .start(start), .upc_entry(upc_entry),
        .length(length), .uinst(uinst), .upc(upc), .issue(issue),
        .clr(clr), .prog_done(prog_done)
    );

    agu u_agu (
        .clk(clk), .rstn(rstn), .clr(clr), .issue(issue), .wr_step(wr_step),
        .a_base(a_base), .b_base(b_base), .d_base(d_base),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b), .wr_addr(wr_addr)
    );

    lane_alu u_alu (
        .clk(clk), .rstn(rstn), .issue(issue), .op(op), .negate(negate),
        .fill_const(fill_const), .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .wr_en(wr_en), .wr_data(wr_data), .wr_step(wr_step), .busy(busy)
    );

endmodule

// File: verilog/lane_alu.sv
`timescale 1ns/1ps

module lane_alu (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               issue,
    input  logic [vpu_isa_pkg::OP_WIDTH-1:0]   op,
    input  logic                               negate,
    input  logic [vpu_isa_pkg::LANE_WIDTH-1:0] fill_const,
    input  logic [vpu_isa_pkg::DATA_WIDTH-1:0] rd_data_a,
    input  logic [vpu_isa_pkg::DATA_WIDTH-1:0] rd_data_b,
    output logic                               wr_en,
    output logic [vpu_isa_pkg::DATA_WIDTH-1:0] wr_data,
    output logic                               wr_step,
    output logic                               busy
);
    import vpu_isa_pkg::*;

    logic                  s1_valid;
    logic                  s2_valid;
    logic [DATA_WIDTH-1:0] result;
    logic [LANE_WIDTH-1:0] a_lane;
    logic [LANE_WIDTH-1:0] b_lane;
    logic [LANE_WIDTH-1:0] r_lane;

    // read data is valid in stage 1
    always_comb begin
        result = '0;
        a_lane = '0;
        b_lane = '0;
        r_lane = '0;
        for (int i = 0; i < N_LANES; i++) begin
            a_lane = rd_data_a[i*LANE_WIDTH +: LANE_WIDTH];
            b_lane = rd_data_b[i*LANE_WIDTH +: LANE_WIDTH];
            case (op)
                OP_VADD: r_lane = a_lane + b_lane;
                OP_VMUL: r_lane = a_lane * b_lane;
                OP_FILL: r_lane = fill_const;
                default: r_lane = '0;
            endcase
            if (negate) begin
                r_lane = -r_lane;
            end
            result[i*LANE_WIDTH +: LANE_WIDTH] = r_lane;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= issue;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            wr_data <= result;
        end
    end

    assign wr_en   = s2_valid;
    assign wr_step = s2_valid;
    assign busy    = s1_valid || s2_valid;

    // lane settings hold while words are in flight
    a_cfg_stable: assert property (@(posedge clk) disable iff (!rstn)
        busy |-> $stable(op) && $stable(negate) && $stable(fill_const));

endmodule

// File: verilog/agu.sv
`timescale 1ns/1ps

module agu (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               clr,
    input  logic                               issue,
    input  logic                               wr_step,
    input  logic [vpu_isa_pkg::ADDR_WIDTH-1:0] a_base,
    input  logic [vpu_isa_pkg::ADDR_WIDTH-1:0] b_base,
    input  logic [vpu_isa_pkg::ADDR_WIDTH-1:0] d_base,
    output logic [vpu_isa_pkg::ADDR_WIDTH-1:0] rd_addr_a,
    output logic [vpu_isa_pkg::ADDR_WIDTH-1:0] rd_addr_b,
    output logic [vpu_isa_pkg::ADDR_WIDTH-1:0] wr_addr
);

    // source counters step with each issued word
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_addr_a <= '0;
            rd_addr_b <= '0;
        end else if (clr) begin
            rd_addr_a <= a_base;
            rd_addr_b <= b_base;
        end else if (issue) begin
            rd_addr_a <= rd_addr_a + 1'b1;
            rd_addr_b <= rd_addr_b + 1'b1;
        end
    end

    // destination trails by two cycles, stepped by the write strobe
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_addr <= '0;
        end else if (clr) begin
            wr_addr <= d_base;
        end else if (wr_step) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

endmodule

// File: verilog/useq.sv
`timescale 1ns/1ps

module useq (
    input  logic                                   clk,
    input  logic                                   rstn,
    input  logic                                   start,
    input  logic [vpu_ucode_pkg::UPC_WIDTH-1:0]    upc_entry,
    input  logic [vpu_isa_pkg::LEN_WIDTH-1:0]      length,
    input  logic [vpu_ucode_pkg::UINST_WIDTH-1:0]  uinst,
    output logic [vpu_ucode_pkg::UPC_WIDTH-1:0]    upc,
    output logic                                   issue,
    output logic                                   clr,
    output logic                                   prog_done
);
    import vpu_isa_pkg::*;
    import vpu_ucode_pkg::*;

    logic [UPC_WIDTH-1:0] cur_pc;
    logic [UPC_WIDTH-1:0] mark_q;
    logic [LEN_WIDTH-1:0] loop_cnt;
    logic                 running;
    logic                 done_q;
    logic                 take_loop;

    // uinst is the word at cur_pc, so upc is the next address
    assign take_loop = running && uinst[UF_LOOP] && (loop_cnt != 1);

    always_comb begin
        if (start) begin
            upc = upc_entry;
        end else if (!running || uinst[UF_DONE]) begin
            upc = cur_pc;
        end else if (take_loop) begin
            upc = mark_q;
        end else begin
            upc = cur_pc + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cur_pc   <= '0;
            mark_q   <= '0;
            loop_cnt <= '0;
            running  <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            cur_pc <= upc;
            if (start) begin
                running  <= 1'b1;
                done_q   <= 1'b0;
                loop_cnt <= length;
            end else if (running) begin
                if (uinst[UF_DONE]) begin
                    running <= 1'b0;
                    done_q  <= 1'b1;
                end
                if (uinst[UF_MARK]) begin
                    mark_q <= cur_pc + 1'b1;
                end
                if (take_loop) begin
                    loop_cnt <= loop_cnt - 1'b1;
                end
            end
        end
    end

    assign issue     = running && uinst[UF_ISSUE];
    assign clr       = running && uinst[UF_CLR];
    assign prog_done = done_q;

    // each program ends in done before stepping off the ROM
    a_upc_range: assert property (@(posedge clk) disable iff (!rstn)
        running && !uinst[UF_DONE] |-> int'(cur_pc) + 1 < UROM_DEPTH);

endmodule

// File: verilog/ucode_rom.sv
`timescale 1ns/1ps

module ucode_rom (
    input  logic                                   clk,
    input  logic [vpu_ucode_pkg::UPC_WIDTH-1:0]    upc,
    output logic [vpu_ucode_pkg::UINST_WIDTH-1:0]  uinst
);
    import vpu_ucode_pkg::*;

    logic [UINST_WIDTH-1:0] rom_word;

    always_comb begin
        rom_word = '0;
        case (upc)
            // vector program
            UPC_VEC:         rom_word[UF_CLR]  = 1'b1;
            UPC_VEC + 5'd1:  rom_word[UF_MARK] = 1'b1;
            UPC_VEC + 5'd2: begin
                rom_word[UF_ISSUE] = 1'b1;
                rom_word[UF_LOOP]  = 1'b1;
            end
            UPC_VEC + 5'd3:  rom_word[UF_DONE] = 1'b1;
            // fill program
            UPC_FILL:        rom_word[UF_CLR]  = 1'b1;
            UPC_FILL + 5'd1: rom_word[UF_MARK] = 1'b1;
            UPC_FILL + 5'd2: begin
                rom_word[UF_ISSUE] = 1'b1;
                rom_word[UF_LOOP]  = 1'b1;
            end
            UPC_FILL + 5'd3: rom_word[UF_DONE] = 1'b1;
            // unused words stop the sequencer
            default:         rom_word[UF_DONE] = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        uinst <= rom_word;
    end

endmodule

// File: verilog/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  vpu_isa_pkg::inst_t                   inst,
    input  logic                                 inst_valid,
    input  logic                                 prog_done,
    input  logic                                 busy,
    output logic                                 inst_credit,
    output logic                                 finish,
    output logic                                 start,
    output logic [vpu_isa_pkg::OP_WIDTH-1:0]     op,
    output logic [vpu_isa_pkg::LEN_WIDTH-1:0]    length,
    output logic                                 negate,
    output logic [vpu_isa_pkg::LANE_WIDTH-1:0]   fill_const,
    output logic [vpu_isa_pkg::ADDR_WIDTH-1:0]   a_base,
    output logic [vpu_isa_pkg::ADDR_WIDTH-1:0]   b_base,
    output logic [vpu_isa_pkg::ADDR_WIDTH-1:0]   d_base,
    output logic [vpu_ucode_pkg::UPC_WIDTH-1:0] upc_entry
);
    import vpu_isa_pkg::*;
    import vpu_ucode_pkg::*;

    inst_t slot_q;
    inst_t inst_q;
    logic  slot_full;
    logic  decoding;
    logic  executing;
    logic  dec_cnt;
    logic  fetch_go;
    logic  is_fill;

    // fetch is the state with neither decode nor execute active
    assign fetch_go = !decoding && !executing && slot_full;
    assign is_fill  = (inst_q.vec.opcode == OP_FILL);
    // prog_done from the previous program is still visible in the start cycle
    assign finish   = executing && !start && prog_done && !busy;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            slot_full   <= 1'b0;
            decoding    <= 1'b0;
            executing   <= 1'b0;
            dec_cnt     <= 1'b0;
            inst_credit <= 1'b0;
            start       <= 1'b0;
        end else begin
            slot_full   <= inst_valid || (slot_full && !fetch_go);
            inst_credit <= fetch_go;
            start       <= decoding && dec_cnt;
            if (fetch_go) begin
                decoding <= 1'b1;
                dec_cnt  <= 1'b0;
            end else if (decoding) begin
                dec_cnt <= 1'b1;
                if (dec_cnt) begin
                    decoding  <= 1'b0;
                    executing <= 1'b1;
                end
            end else if (finish) begin
                executing <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            slot_q <= inst;
        end
        if (fetch_go) begin
            inst_q <= slot_q;
        end
    end

    // first decode cycle picks the view by opcode
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            op        <= '0;
            length    <= '0;
            negate    <= 1'b0;
            upc_entry <= '0;
        end else if (decoding && !dec_cnt) begin
            op        <= inst_q.vec.opcode;
            length    <= inst_q.vec.length;
            negate    <= is_fill ? 1'b0 : inst_q.vec.negate;
            upc_entry <= is_fill ? UPC_FILL : UPC_VEC;
        end
    end

    always_ff @(posedge clk) begin
        if (decoding && !dec_cnt) begin
            d_base     <= inst_q.vec.d_base;
            a_base     <= is_fill ? '0 : inst_q.vec.a_base;
            b_base     <= is_fill ? '0 : inst_q.vec.b_base;
            fill_const <= is_fill ? inst_q.fill.value : '0;
        end
    end

    // host only sends while holding the single credit
    a_no_overrun: assert property (@(posedge clk) disable iff (!rstn)
        inst_valid |-> !slot_full);

    a_len_nonzero: assert property (@(posedge clk) disable iff (!rstn)
        start |-> length != '0);

endmodule

// File: verilog/vpu_ucode_pkg.sv
package vpu_ucode_pkg;

    localparam int UINST_WIDTH = 8;
    localparam int UPC_WIDTH   = 5;
    localparam int UROM_DEPTH  = 32;

    // microinstruction bit positions
    localparam int UF_DONE  = 0;
    localparam int UF_MARK  = 1;
    localparam int UF_LOOP  = 2;
    localparam int UF_ISSUE = 3;
    localparam int UF_CLR   = 4;

    // program entry points
    localparam logic [UPC_WIDTH-1:0] UPC_VEC  = 5'd0;
    localparam logic [UPC_WIDTH-1:0] UPC_FILL = 5'd8;

endpackage

// File: verilog/vpu_isa_pkg.sv
package vpu_isa_pkg;

    localparam int INST_WIDTH = 40;
    localparam int ADDR_WIDTH = 8;
    localparam int DATA_WIDTH = 64;
    localparam int LANE_WIDTH = 16;
    localparam int N_LANES    = 4;
    localparam int LEN_WIDTH  = 6;
    localparam int OP_WIDTH   = 3;

    localparam logic [OP_WIDTH-1:0] OP_VADD = 3'd1;
    localparam logic [OP_WIDTH-1:0] OP_VMUL = 3'd2;
    localparam logic [OP_WIDTH-1:0] OP_FILL = 3'd3;

    // opcode, length and d_base line up in both views
    typedef struct packed {
        logic [OP_WIDTH-1:0]   opcode;
        logic [LEN_WIDTH-1:0]  length;
        logic [ADDR_WIDTH-1:0] d_base;
        logic [ADDR_WIDTH-1:0] a_base;
        logic [ADDR_WIDTH-1:0] b_base;
        logic                  negate;
        logic [INST_WIDTH-OP_WIDTH-LEN_WIDTH-3*ADDR_WIDTH-2:0] spare;
    } inst_vec_t;

    typedef struct packed {
        logic [OP_WIDTH-1:0]   opcode;
        logic [LEN_WIDTH-1:0]  length;
        logic [ADDR_WIDTH-1:0] d_base;
        logic [LANE_WIDTH-1:0] value;
        logic [INST_WIDTH-OP_WIDTH-LEN_WIDTH-ADDR_WIDTH-LANE_WIDTH-1:0] spare;
    } inst_fill_t;

    typedef union packed {
        inst_vec_t  vec;
        inst_fill_t fill;
    } inst_t;

endpackage
